//--- tb.f
source/i2c_pkg.sv
source/i2c_bit_timer.sv
source/i2c_read_capture.sv
source/i2c_sequencer.sv
source/i2c_master_top.sv
tb/i2c_master_properties.sv
tb/i2c_master_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it once
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module i2c_master_tb -f tb.f

# the simulation exits nonzero on a failure, the search below decides the result
sim_out="$(./obj_dir/Vi2c_master_tb 2>&1)" || true
echo "$sim_out"

if grep -q "Finished with no errors" <<< "$sim_out"; then
	exit 0
else
	exit 1
fi

//--- tb/i2c_master_tb.sv
`default_nettype none

module i2c_master_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import i2c_pkg::*;

	// number of polls in the stimulus table
	localparam int NUM_ROWS = 5;

	logic clk = 1'b0;
	logic rst_n;
	logic start;
	i2c_cmd_t commands [0:NUM_CMDS-1];
	byte_t data_write [0:NUM_BYTES-1];
	byte_t data_read [0:NUM_BYTES-1];
	logic busy;
	logic done;
	logic scl;
	logic sda_drive_low;

	// open-drain sda, low when the controller or the target pulls it
	logic tgt_pull = 1'b0;
	logic sda;
	assign sda = !(sda_drive_low || tgt_pull);

	// stimulus table, one poll per row
	i2c_cmd_t tbl_cmds [0:NUM_ROWS-1][0:NUM_CMDS-1];
	byte_t tbl_wdata [0:NUM_ROWS-1][0:NUM_BYTES-1];
	logic [NUM_BYTES-1:0] tbl_nack [0:NUM_ROWS-1];
	logic tbl_done [0:NUM_ROWS-1];
	int cur_row = 0;

	// what the target saw and sent, kept over all polls
	byte_t wr_seen [$];
	byte_t rd_sent [$];
	logic ack_seen [$];
	int n_start = 0;
	int n_stop = 0;
	int n_done = 0;

	// contents that data_read should hold, built from the bytes the target sent
	byte_t exp_read [0:NUM_BYTES-1];
	int cycles = 0;
	int limit = 0;

	always #4 clk = !clk;

	i2c_master_top dut_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.start         (start),
		.commands      (commands),
		.data_write    (data_write),
		.sda_in        (sda),
		.busy          (busy),
		.done          (done),
		.data_read     (data_read),
		.scl           (scl),
		.sda_drive_low (sda_drive_low)
	);

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
		$display("Finished with errors");
		$fatal(1, "stopped at the first mismatch");
	endtask

	// one nibble per command in cmds, entry 0 in the top nibble
	// byte 0 of wdata sits in the top byte
	task automatic set_row(input int r, input logic [63:0] cmds, input logic [47:0] wdata,
		input logic [5:0] nack, input logic exp_done);
		for (int i = 0; i < NUM_CMDS; i++) begin
			tbl_cmds[r][i] = i2c_cmd_t'(cmds[60 - 4*i +: 3]);
		end
		for (int i = 0; i < NUM_BYTES; i++) begin
			tbl_wdata[r][i] = wdata[40 - 8*i +: 8];
		end
		tbl_nack[r] = nack;
		tbl_done[r] = exp_done;
	endtask

	// galois lfsr, one step per bit the target sends
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// the n-th byte command of a row, IDLE_CMD past the end of the list
	function automatic i2c_cmd_t byte_kind(input int row, input int n);
		int seen;
		seen = 0;
		for (int i = 0; i < NUM_CMDS; i++) begin
			if (tbl_cmds[row][i] == IDLE_CMD) begin
				return IDLE_CMD;
			end
			if (tbl_cmds[row][i] inside {WRITE_BYTE, READ_BYTE_ACK, READ_BYTE_NACK}) begin
				if (seen == n) begin
					return tbl_cmds[row][i];
				end
				seen++;
			end
		end
		return IDLE_CMD;
	endfunction

	// target model, watches scl and sda one clock behind the bus
	// it changes its own pull only when scl has just dropped
	logic prev_scl = 1'b0;
	logic prev_sda = 1'b1;
	logic active = 1'b0;
	logic bit_seen = 1'b0;
	int bit_num = 0;
	int byte_num = 0;
	int wr_idx = 0;
	byte_t shift = '0;
	logic [31:0] lfsr = 32'hbd30_3c8d;

	always @(posedge clk) begin : target_model
		i2c_cmd_t kind;
		logic is_rd;
		if (scl && prev_scl && prev_sda && !sda) begin
			// sda falling under a high scl is a START
			active = 1'b1;
			bit_seen = 1'b0;
			bit_num = 0;
			byte_num = 0;
			wr_idx = 0;
			n_start++;
		end else if (scl && prev_scl && !prev_sda && sda) begin
			active = 1'b0;
			n_stop++;
		end else if (active && scl && !prev_scl) begin
			bit_seen = 1'b1;
			kind = byte_kind(cur_row, byte_num);
			if ((bit_num < 8) && (kind == WRITE_BYTE)) begin
				shift = {shift[6:0], sda};
			end
			if ((bit_num == 8) && (kind inside {READ_BYTE_ACK, READ_BYTE_NACK})) begin
				ack_seen.push_back(!sda);
			end
		end else if (active && !scl && prev_scl) begin
			if (bit_seen) begin
				bit_seen = 1'b0;
				bit_num = (bit_num == 8) ? 0 : bit_num + 1;
				byte_num = (bit_num == 0) ? byte_num + 1 : byte_num;
			end
			kind = byte_kind(cur_row, byte_num);
			is_rd = (kind == READ_BYTE_ACK) || (kind == READ_BYTE_NACK);
			// set up the level for the bit that comes next
			if ((bit_num == 8) && (kind == WRITE_BYTE)) begin
				wr_seen.push_back(shift);
				tgt_pull <= !tbl_nack[cur_row][wr_idx];
				wr_idx++;
			end else if ((bit_num == 8) && is_rd) begin
				rd_sent.push_back(shift);
				tgt_pull <= 1'b0;
			end else if (is_rd) begin
				shift = {shift[6:0], lfsr[0]};
				tgt_pull <= !lfsr[0];
				lfsr = lfsr_step(lfsr);
			end else begin
				tgt_pull <= 1'b0;
			end
		end
		prev_scl = scl;
		prev_sda = sda;
	end

	always @(posedge clk) begin
		if (done) begin
			n_done <= n_done + 1;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if ((limit != 0) && (cycles > limit)) begin
			$display("timeout: the polls did not finish within %0d clock cycles", limit);
			$display("Finished with errors");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	task automatic run_poll(input int r);
		int wr_base;
		int rd_base;
		int ack_base;
		int start_base;
		int stop_base;
		int done_base;
		int n_wr;
		int n_rd;
		logic halted;
		i2c_cmd_t c;
		wr_base = wr_seen.size();
		rd_base = rd_sent.size();
		ack_base = ack_seen.size();
		start_base = n_start;
		stop_base = n_stop;
		done_base = n_done;
		n_wr = 0;
		n_rd = 0;
		halted = 1'b0;
		cur_row = r;
		for (int i = 0; i < NUM_CMDS; i++) begin
			commands[i] <= tbl_cmds[r][i];
		end
		for (int i = 0; i < NUM_BYTES; i++) begin
			data_write[i] <= tbl_wdata[r][i];
		end
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		@(posedge clk);
		assert (busy) else report_mismatch("busy", 32'(busy), 32'h1);
		// a second start in the middle of the poll has to be ignored
		repeat (8) @(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		do begin
			@(posedge clk);
		end while (busy);
		assert (done == tbl_done[r]) else report_mismatch("done", 32'(done), 32'(tbl_done[r]));
		repeat (3) @(posedge clk);
		// walk the list as the bus should have run it, a nacked write ends it
		for (int i = 0; (i < NUM_CMDS) && !halted; i++) begin
			c = tbl_cmds[r][i];
			if (c == IDLE_CMD) begin
				halted = 1'b1;
			end else if (c == WRITE_BYTE) begin
				assert (wr_seen[wr_base + n_wr] == tbl_wdata[r][n_wr])
					else report_mismatch("target write byte", 32'(wr_seen[wr_base + n_wr]),
						32'(tbl_wdata[r][n_wr]));
				halted = tbl_nack[r][n_wr];
				n_wr++;
			end else if ((c == READ_BYTE_ACK) || (c == READ_BYTE_NACK)) begin
				assert (ack_seen[ack_base + n_rd] == (c == READ_BYTE_ACK))
					else report_mismatch("controller ack", 32'(ack_seen[ack_base + n_rd]),
						32'(c == READ_BYTE_ACK));
				exp_read[n_rd] = rd_sent[rd_base + n_rd];
				n_rd++;
			end
		end
		assert (wr_seen.size() - wr_base == n_wr)
			else report_mismatch("target write count", wr_seen.size() - wr_base, n_wr);
		assert (rd_sent.size() - rd_base == n_rd)
			else report_mismatch("target read count", rd_sent.size() - rd_base, n_rd);
		assert (n_start - start_base == 1)
			else report_mismatch("START count", n_start - start_base, 1);
		assert (n_stop - stop_base == 1)
			else report_mismatch("STOP count", n_stop - stop_base, 1);
		assert (n_done - done_base == 32'(tbl_done[r]))
			else report_mismatch("done pulses", n_done - done_base, 32'(tbl_done[r]));
		for (int i = 0; i < NUM_BYTES; i++) begin
			assert (data_read[i] == exp_read[i])
				else report_mismatch($sformatf("data_read[%0d]", i), 32'(data_read[i]),
					32'(exp_read[i]));
		end
	endtask

	initial begin
		rst_n = 1'b0;
		start = 1'b0;
		for (int i = 0; i < NUM_CMDS; i++) begin
			commands[i] = IDLE_CMD;
		end
		for (int i = 0; i < NUM_BYTES; i++) begin
			data_write[i] = '0;
			exp_read[i] = '0;
		end
		// two writes, reads ending in nack, a nack on the second write,
		// six reads, then two reads that leave the upper slots alone
		set_row(0, 64'h1332_0000_0000_0000, 48'ha53c_0000_0000, 6'b000000, 1'b1);
		set_row(1, 64'h1344_5200_0000_0000, 48'h9100_0000_0000, 6'b000000, 1'b1);
		set_row(2, 64'h1333_2000_0000_0000, 48'h5aa5_c300_0000, 6'b000010, 1'b0);
		set_row(3, 64'h1444_4452_0000_0000, 48'h0000_0000_0000, 6'b000000, 1'b1);
		set_row(4, 64'h1452_0000_0000_0000, 48'h0000_0000_0000, 6'b000000, 1'b1);
		for (int r = 0; r < NUM_ROWS; r++) begin
			for (int i = 0; i < NUM_CMDS; i++) begin
				if (tbl_cmds[r][i] != IDLE_CMD) begin
					limit += 36;
				end
			end
			limit += 100;
		end
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		for (int r = 0; r < NUM_ROWS; r++) begin
			run_poll(r);
		end
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/i2c_master_properties.sv
`default_nettype none

module i2c_master_properties (
	input wire logic              clk,
	input wire logic              rst_n,
	input wire logic              busy,
	input wire logic              done,
	input wire logic              scl,
	input wire logic              sda_drive_low,
	input wire i2c_pkg::subbit_t  subbit,
	input wire i2c_pkg::i2c_cmd_t cur_cmd
);

	timeunit 1ns;
	timeprecision 100ps;

	import i2c_pkg::*;

	// no clock pulses on the bus between polls
	scl_rests_low: assert property (@(posedge clk) disable iff (!rst_n) !busy |-> !scl)
		else $error("scl high while the controller is idle");

	// done only in the first idle cycle after a poll
	done_after_poll: assert property (@(posedge clk) disable iff (!rst_n) done |-> $fell(busy))
		else $error("done outside the cycle after busy fell");

	// data moves under a low scl, START and STOP move sda in mid-high on purpose
	sda_moves_safely: assert property (@(posedge clk) disable iff (!rst_n)
		$changed(sda_drive_low) |-> !scl ||
			(((cur_cmd == START) || (cur_cmd == STOP)) && (subbit == subbit_t'(2))))
		else $error("sda changed while scl was high");

endmodule

bind i2c_master_top i2c_master_properties props_i (
	.clk           (clk),
	.rst_n         (rst_n),
	.busy          (busy),
	.done          (done),
	.scl           (scl),
	.sda_drive_low (sda_drive_low),
	.subbit        (subbit),
	.cur_cmd       (cur_cmd)
);

`default_nettype wire

//--- source/i2c_master_top.sv
`default_nettype none

module i2c_master_top (
	input  wire logic               clk,
	input  wire logic               rst_n,
	input  wire logic               start,
	input  wire i2c_pkg::i2c_cmd_t  commands [0:i2c_pkg::NUM_CMDS-1],
	input  wire i2c_pkg::byte_t     data_write [0:i2c_pkg::NUM_BYTES-1],
	input  wire logic               sda_in,
	output logic                    busy,
	output logic                    done,
	output i2c_pkg::byte_t          data_read [0:i2c_pkg::NUM_BYTES-1],
	output logic                    scl,
	output logic                    sda_drive_low
);

	import i2c_pkg::*;

	// sequencer to timer
	logic running;
	i2c_cmd_t cur_cmd;
	logic load_byte;

	// timer back to sequencer and capture
	subbit_t subbit;
	bit_cnt_t bit_cnt;

	// sequencer to capture
	logic sample_bit;
	logic store_byte;
	byte_idx_t read_idx;

	// phase counter, scl and bits-remaining count
	i2c_bit_timer timer_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.running   (running),
		.cur_cmd   (cur_cmd),
		.load_byte (load_byte),
		.subbit    (subbit),
		.bit_cnt   (bit_cnt),
		.scl       (scl)
	);

	// walks the command list and decides the sda level
	i2c_sequencer seq_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.start         (start),
		.commands      (commands),
		.data_write    (data_write),
		.subbit        (subbit),
		.bit_cnt       (bit_cnt),
		.sda_in        (sda_in),
		.running       (running),
		.cur_cmd       (cur_cmd),
		.load_byte     (load_byte),
		.sample_bit    (sample_bit),
		.store_byte    (store_byte),
		.read_idx      (read_idx),
		.sda_drive_low (sda_drive_low),
		.busy          (busy),
		.done          (done)
	);

	// gathers bytes sent by the target into the read slots
	i2c_read_capture capture_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.sample_bit (sample_bit),
		.store_byte (store_byte),
		.bit_cnt    (bit_cnt),
		.read_idx   (read_idx),
		.sda_in     (sda_in),
		.data_read  (data_read)
	);

endmodule

`default_nettype wire

//--- source/i2c_sequencer.sv
`default_nettype none

module i2c_sequencer (
	input  wire logic               clk,
	input  wire logic               rst_n,
	input  wire logic               start,
	input  wire i2c_pkg::i2c_cmd_t  commands [0:i2c_pkg::NUM_CMDS-1],
	input  wire i2c_pkg::byte_t     data_write [0:i2c_pkg::NUM_BYTES-1],
	input  wire i2c_pkg::subbit_t   subbit,
	input  wire i2c_pkg::bit_cnt_t  bit_cnt,
	input  wire logic               sda_in,
	output logic                    running,
	output i2c_pkg::i2c_cmd_t       cur_cmd,
	output logic                    load_byte,
	output logic                    sample_bit,
	output logic                    store_byte,
	output i2c_pkg::byte_idx_t      read_idx,
	output logic                    sda_drive_low,
	output logic                    busy,
	output logic                    done
);

	import i2c_pkg::*;

	// read and write commands both shift nine bits
	function automatic logic is_byte_cmd(input i2c_cmd_t c);
		return (c == WRITE_BYTE) || (c == READ_BYTE_ACK) || (c == READ_BYTE_NACK);
	endfunction

	function automatic logic is_read_cmd(input i2c_cmd_t c);
		return (c == READ_BYTE_ACK) || (c == READ_BYTE_NACK);
	endfunction

	// position of the executing command in the list
	cmd_idx_t cmd_ptr;

	// next free write slot and next free read slot
	byte_idx_t wr_ptr;
	byte_idx_t rd_ptr;

	// ack seen on the last written byte, and sticky failure for the poll
	logic acked;
	logic failed;

	// running one cycle late, used to find the end of a poll
	logic running_d1;

	// a start pulse only counts while no poll is in progress
	logic launch;

	// phase 3 of the final bit of the current command
	logic cmd_last;

	// command that follows the current one
	i2c_cmd_t nxt_cmd;

	// byte the current write command is shifting
	byte_t wr_byte;
	logic [$clog2(BYTE_W)-1:0] wr_bit_pos;

	assign launch = start && !running;

	// start and stop take a single bit, byte commands end after the ack bit
	always_comb begin
		cmd_last = 1'b0;
		if (running && (subbit == subbit_t'(SUBBITS - 1))) begin
			if ((cur_cmd == START) || (cur_cmd == STOP)) begin
				cmd_last = 1'b1;
			end else if (is_byte_cmd(cur_cmd)) begin
				cmd_last = (bit_cnt == '0);
			end
		end
	end

	// pick the next command
	// a nacked write jumps to STOP, and the STOP that closes a failed poll
	// goes straight to IDLE_CMD instead of resuming the list
	always_comb begin
		if (!running) begin
			nxt_cmd = commands[0];
		end else if ((cur_cmd == WRITE_BYTE) && !acked) begin
			nxt_cmd = STOP;
		end else if ((cur_cmd == STOP) && failed) begin
			nxt_cmd = IDLE_CMD;
		end else if (cmd_ptr == cmd_idx_t'(NUM_CMDS - 1)) begin
			// past the end of the list the poll simply ends
			nxt_cmd = IDLE_CMD;
		end else begin
			nxt_cmd = commands[cmd_ptr + cmd_idx_t'(1)];
		end
	end

	// the bit counter has to hold 8 by phase 0 of any byte command
	assign load_byte = (launch || cmd_last) && is_byte_cmd(nxt_cmd);

	// read strobes for the capture block
	// data bits are sampled mid-high, the byte is stored as the ack bit ends
	assign sample_bit = running && is_read_cmd(cur_cmd) &&
		(subbit == subbit_t'(2)) && (bit_cnt != '0);
	assign store_byte = running && is_read_cmd(cur_cmd) &&
		(subbit == subbit_t'(SUBBITS - 1)) && (bit_cnt == '0);

	assign read_idx = rd_ptr;

	// write data lookup, out-of-range slots send zeros
	assign wr_byte = (wr_ptr < byte_idx_t'(NUM_BYTES)) ? data_write[wr_ptr] : '0;
	assign wr_bit_pos = $bits(wr_bit_pos)'(bit_cnt - bit_cnt_t'(1));

	// sda level for every phase
	// all inputs are registers, so the level only moves on clock edges
	always_comb begin
		sda_drive_low = 1'b0;
		if (running) begin
			case (cur_cmd)
				// sda falls at phase 2 while scl is high
				START: sda_drive_low = (subbit >= subbit_t'(2));
				// sda rises at phase 2 while scl is high
				STOP: sda_drive_low = (subbit < subbit_t'(2));
				WRITE_BYTE: begin
					// release on the ack bit so the target can answer
					if (bit_cnt != '0) begin
						sda_drive_low = !wr_byte[wr_bit_pos];
					end
				end
				// the target owns the data bits, we pull low for ack
				READ_BYTE_ACK: sda_drive_low = (bit_cnt == '0);
				// a nack is just a released ninth bit
				READ_BYTE_NACK: sda_drive_low = 1'b0;
				default: sda_drive_low = 1'b0;
			endcase
		end
	end

	// poll control registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			running <= 1'b0;
			running_d1 <= 1'b0;
			cur_cmd <= IDLE_CMD;
			cmd_ptr <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			acked <= 1'b0;
			failed <= 1'b0;
		end else begin
			running_d1 <= running;
			if (launch) begin
				running <= 1'b1;
				cur_cmd <= nxt_cmd;
				cmd_ptr <= '0;
				wr_ptr <= '0;
				rd_ptr <= '0;
				acked <= 1'b0;
				failed <= 1'b0;
			end else if (running) begin
				if (cur_cmd == IDLE_CMD) begin
					// one cycle on IDLE_CMD, then the poll is over
					running <= 1'b0;
				end else if (cmd_last) begin
					cur_cmd <= nxt_cmd;
					cmd_ptr <= cmd_ptr + cmd_idx_t'(1);
					if (cur_cmd == WRITE_BYTE) begin
						wr_ptr <= wr_ptr + byte_idx_t'(1);
						if (!acked) begin
							failed <= 1'b1;
						end
					end
				end
				// the target answers a write at phase 2 of the ninth bit
				if ((cur_cmd == WRITE_BYTE) && (bit_cnt == '0) &&
					(subbit == subbit_t'(2))) begin
					acked <= !sda_in;
				end
				if (store_byte) begin
					rd_ptr <= rd_ptr + byte_idx_t'(1);
				end
			end
		end
	end

	assign busy = running;

	// the poll ended last cycle, and only a clean poll reports done
	assign done = running_d1 && !running && !failed;

endmodule

`default_nettype wire

//--- source/i2c_read_capture.sv
`default_nettype none

module i2c_read_capture (
	input  wire logic               clk,
	input  wire logic               rst_n,
	input  wire logic               sample_bit,
	input  wire logic               store_byte,
	input  wire i2c_pkg::bit_cnt_t  bit_cnt,
	input  wire i2c_pkg::byte_idx_t read_idx,
	input  wire logic               sda_in,
	output i2c_pkg::byte_t          data_read [0:i2c_pkg::NUM_BYTES-1]
);

	import i2c_pkg::*;

	// byte under assembly while the target shifts it out
	byte_t asm_byte;

	// bit position of the current data bit inside the byte
	logic [$clog2(BYTE_W)-1:0] bit_pos;

	// a read slot beyond the array is never written
	logic slot_valid;

	// bit_cnt runs 8 down to 1 over the data bits, so the msb lands first
	assign bit_pos = $bits(bit_pos)'(bit_cnt - bit_cnt_t'(1));

	assign slot_valid = (read_idx < byte_idx_t'(NUM_BYTES));

	// assembly register
	// the sequencer only raises sample_bit at phase 2 of a data bit,
	// while scl is high and the target holds sda steady
	always_ff @(posedge clk) begin
		if (sample_bit) begin
			asm_byte[bit_pos] <= sda_in;
		end
	end

	// read slots
	// the store strobe comes with phase 3 of the ack bit, so the byte shows up
	// in data_read one cycle later
	// slots keep their contents across polls and are only cleared by reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_BYTES; i++) begin
				data_read[i] <= '0;
			end
		end else if (store_byte && slot_valid) begin
			data_read[read_idx] <= asm_byte;
		end
	end

endmodule

`default_nettype wire

//--- source/i2c_bit_timer.sv
`default_nettype none

module i2c_bit_timer (
	input  wire logic               clk,
	input  wire logic               rst_n,
	input  wire logic               running,
	input  wire i2c_pkg::i2c_cmd_t  cur_cmd,
	input  wire logic               load_byte,
	output i2c_pkg::subbit_t        subbit,
	output i2c_pkg::bit_cnt_t       bit_cnt,
	output logic                    scl
);

	import i2c_pkg::*;

	// the phase counter only moves while a real command is on the bus
	logic phase_active;

	// last phase of a bit, where the bit counter steps and commands end
	logic phase_last;

	assign phase_active = running && (cur_cmd != IDLE_CMD);
	assign phase_last = (subbit == subbit_t'(SUBBITS - 1));

	// sub-bit counter
	// phase 0 sets up sda with scl low, phases 1 and 2 hold scl high,
	// phase 3 pulls scl low again before the next bit
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			subbit <= '0;
		end else if (!phase_active) begin
			// restart from phase 0 so the next command begins aligned
			subbit <= '0;
		end else if (phase_last) begin
			subbit <= '0;
		end else begin
			subbit <= subbit + subbit_t'(1);
		end
	end

	// scl is decoded straight from the phase
	// with subbit held at 0 outside a poll, scl rests low
	assign scl = (subbit == subbit_t'(1)) || (subbit == subbit_t'(2));

	// bits-remaining counter for the byte being shifted
	// 8 means the msb is on the bus, 0 means the ack bit is on the bus
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt <= '0;
		end else if (load_byte) begin
			// the sequencer requests a load at the end of the previous command,
			// so the count is ready at phase 0 of the byte command
			bit_cnt <= bit_cnt_t'(BYTE_W);
		end else if (!running) begin
			bit_cnt <= '0;
		end else if (phase_active && phase_last && (bit_cnt != '0)) begin
			// one step per bit, taken as scl drops at the end of the bit
			bit_cnt <= bit_cnt - bit_cnt_t'(1);
		end
	end

endmodule

`default_nettype wire

//--- source/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

	// length of the command list that a poll walks through
	localparam int NUM_CMDS = 16;

	// number of write slots and number of read slots
	localparam int NUM_BYTES = 6;

	// data byte width on the bus
	localparam int BYTE_W = 8;

	// clk cycles spent on every scl bit, one per sub-bit phase
	localparam int SUBBITS = 4;

	// bus commands as they appear in the command list
	// a listed IDLE_CMD marks the end of the poll
	typedef enum logic [2:0] {
		IDLE_CMD       = 3'd0,
		START          = 3'd1,
		STOP           = 3'd2,
		WRITE_BYTE     = 3'd3,
		READ_BYTE_ACK  = 3'd4,
		READ_BYTE_NACK = 3'd5
	} i2c_cmd_t;

	// index of the command currently executing
	typedef logic [$clog2(NUM_CMDS)-1:0] cmd_idx_t;

	// index into the write and read byte arrays
	typedef logic [$clog2(NUM_BYTES)-1:0] byte_idx_t;

	// bits still to go in a byte, 8 down to 0, where 0 is the ack bit
	typedef logic [$clog2(BYTE_W+1)-1:0] bit_cnt_t;

	// phase inside one scl bit
	typedef logic [$clog2(SUBBITS)-1:0] subbit_t;

	typedef logic [BYTE_W-1:0] byte_t;

endpackage

`default_nettype wire
